// File: rtl/aes_key_pkg.sv
`default_nettype none

package aes_key_pkg;

    localparam int NB_BYTE       = 8;
    localparam int N_BYTES_STATE = 16;
    localparam int NB_STATE      = N_BYTES_STATE * NB_BYTE;  // 128-bit round key
    localparam int NB_WORD       = 4 * NB_BYTE;
    localparam int N_ROUNDS      = 10;                       // AES-128

    // Round keys 0 to N_ROUNDS, round 0 in the lowest bits
    localparam int NB_KEY_VECTOR = (N_ROUNDS + 1) * NB_STATE;

    // Wide enough to index any round key
    localparam int NB_ROUND_INDEX = $clog2(N_ROUNDS + 1);

    // Multiply by x in GF(2^8), reduction polynomial 0x11b
    function automatic logic [NB_BYTE-1:0] xtime(input logic [NB_BYTE-1:0] b);
        return {b[NB_BYTE-2:0], 1'b0} ^ (b[NB_BYTE-1] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [NB_BYTE-1:0] gf_mul(
        input logic [NB_BYTE-1:0] a,
        input logic [NB_BYTE-1:0] b
    );
        logic [NB_BYTE-1:0] product;
        logic [NB_BYTE-1:0] addend;
        product = '0;
        addend  = a;
        for (int i = 0; i < NB_BYTE; i++)
        begin
            if (b[i])
                product = product ^ addend;
            addend = xtime(addend);
        end
        return product;
    endfunction

    // Inverse as a^254, which maps 0 to 0 as the S-box wants
    function automatic logic [NB_BYTE-1:0] gf_inv(input logic [NB_BYTE-1:0] a);
        logic [NB_BYTE-1:0] result;
        logic [NB_BYTE-1:0] power;
        result = 8'h01;
        power  = a;
        for (int i = 1; i < NB_BYTE; i++)
        begin
            power  = gf_mul(power, power);    // a^(2^i)
            result = gf_mul(result, power);
        end
        return result;
    endfunction

    // S-box: field inverse followed by the affine map
    function automatic logic [NB_BYTE-1:0] sbox(input logic [NB_BYTE-1:0] a);
        logic [NB_BYTE-1:0] b;
        b = gf_inv(a);
        return b
            ^ {b[6:0], b[7]}
            ^ {b[5:0], b[7:6]}
            ^ {b[4:0], b[7:5]}
            ^ {b[3:0], b[7:4]}
            ^ 8'h63;
    endfunction

    function automatic logic [NB_WORD-1:0] sub_word(input logic [NB_WORD-1:0] w);
        logic [NB_WORD-1:0] result;
        for (int i = 0; i < NB_WORD / NB_BYTE; i++)
        begin
            result[i*NB_BYTE +: NB_BYTE] = sbox(w[i*NB_BYTE +: NB_BYTE]);
        end
        return result;
    endfunction

    // Top byte wraps to the bottom
    function automatic logic [NB_WORD-1:0] rot_word(input logic [NB_WORD-1:0] w);
        return {w[NB_WORD-NB_BYTE-1:0], w[NB_WORD-1 -: NB_BYTE]};
    endfunction

    // Round constant for rounds 1 to 10, i.e. x^(round-1)
    function automatic logic [NB_BYTE-1:0] rcon(input logic [NB_ROUND_INDEX-1:0] round);
        logic [NB_BYTE-1:0] value;
        value = 8'h01;
        for (int i = 1; i < N_ROUNDS; i++)
        begin
            if (i < round)
                value = xtime(value);
        end
        return value;
    endfunction

endpackage

`default_nettype wire

// File: rtl/key_command_decoder.sv
`default_nettype none

module key_command_decoder
    import aes_key_pkg::*;
(
    input  wire                 i_clock,
    input  wire                 i_reset,
    input  wire                 i_command_valid,   // One-cycle strobe
    input  wire                 i_command_load,    // 1 load, 0 preview
    input  wire [NB_STATE-1:0]  i_cipher_key,
    input  wire                 i_expand_done,
    input  wire                 i_advance,
    input  wire                 i_switch_done,
    input  wire                 i_preview_done,
    output logic                o_expand_start,
    output logic [NB_STATE-1:0] o_key,
    output logic                o_trigger_loading,
    output logic                o_trigger_muxing,
    output logic                o_busy,
    output logic                o_command_rejected
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXPANDING,
        ST_SWITCHING
    } state_t;

    state_t state;
    logic   load_command;      // Kind of the command in flight
    logic   trigger_pending;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state              <= ST_IDLE;
            load_command       <= 1'b0;
            trigger_pending    <= 1'b0;
            o_expand_start     <= 1'b0;
            o_command_rejected <= 1'b0;
        end
        else
        begin
            o_expand_start     <= 1'b0;
            o_command_rejected <= i_command_valid && (state != ST_IDLE);
            case (state)
                ST_IDLE:
                begin
                    if (i_command_valid)
                    begin
                        state          <= ST_EXPANDING;
                        load_command   <= i_command_load;
                        o_expand_start <= 1'b1;
                    end
                end
                ST_EXPANDING:
                begin
                    if (i_expand_done)
                    begin
                        state           <= ST_SWITCHING;
                        trigger_pending <= 1'b1;
                    end
                end
                ST_SWITCHING:
                begin
                    // The switcher takes the trigger on an advance cycle
                    if (trigger_pending && i_advance)
                        trigger_pending <= 1'b0;
                    if (i_switch_done || i_preview_done)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (state == ST_IDLE && i_command_valid)
            o_key <= i_cipher_key;
    end

    assign o_trigger_loading = trigger_pending && load_command;
    assign o_trigger_muxing  = trigger_pending && !load_command;
    assign o_busy            = (state != ST_IDLE);

endmodule

`default_nettype wire

// File: rtl/key_expander.sv
`default_nettype none

module key_expander
    import aes_key_pkg::*;
(
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire                      i_start,   // One-cycle pulse
    input  wire [NB_STATE-1:0]       i_key,
    output logic [NB_KEY_VECTOR-1:0] o_round_key_vector,
    output logic                     o_done
);

    logic [NB_ROUND_INDEX-1:0] round;       // Next round to compute
    logic                      running;
    logic [NB_STATE-1:0]       prev_key;
    logic [NB_STATE-1:0]       base_key;
    logic [NB_ROUND_INDEX-1:0] base_round;
    logic [NB_WORD-1:0]        temp_word;
    logic [NB_STATE-1:0]       next_key;

    // Round 1 comes straight from the input key on the start cycle
    assign base_key   = i_start ? i_key : prev_key;
    assign base_round = i_start ? NB_ROUND_INDEX'(1) : round;

    // Word 0 sits in the top 32 bits
    always_comb
    begin
        temp_word = sub_word(rot_word(base_key[NB_WORD-1:0]))
                  ^ {rcon(base_round), {(NB_WORD - NB_BYTE){1'b0}}};
        next_key[127:96] = base_key[127:96] ^ temp_word;
        next_key[95:64]  = base_key[95:64] ^ next_key[127:96];
        next_key[63:32]  = base_key[63:32] ^ next_key[95:64];
        next_key[31:0]   = base_key[31:0] ^ next_key[63:32];
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            running <= 1'b0;
            round   <= '0;
            o_done  <= 1'b0;
        end
        else
        begin
            o_done <= running && (round == NB_ROUND_INDEX'(N_ROUNDS));  // Last key written
            if (i_start)
            begin
                running <= 1'b1;
                round   <= NB_ROUND_INDEX'(2);
            end
            else if (running)
            begin
                if (round == NB_ROUND_INDEX'(N_ROUNDS))
                    running <= 1'b0;
                round <= round + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_start)
            o_round_key_vector[NB_STATE-1:0] <= i_key;  // Round 0 is the key itself
        if (i_start || running)
        begin
            o_round_key_vector[base_round*NB_STATE +: NB_STATE] <= next_key;
            prev_key <= next_key;
        end
    end

endmodule

`default_nettype wire

// File: rtl/key_scheduler_switcher.sv
`default_nettype none

module key_scheduler_switcher
    import aes_key_pkg::*;
#(
    parameter int ROUND_FIRST_DELAY  = 1,   // Advance cycles at round 0
    parameter int ROUND_MIDDLE_DELAY = 2,   // Advance cycles at each middle round
    parameter int ROUND_LAST_DELAY   = 2    // Advance cycles at the last round
)
(
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire                      i_valid,            // Round pipeline advances
    input  wire                      i_trigger_loading,
    input  wire                      i_trigger_muxing,
    input  wire [NB_KEY_VECTOR-1:0]  i_round_key_vector,
    output logic [NB_KEY_VECTOR-1:0] o_round_key_vector,
    output logic                     o_loading_done,
    output logic                     o_muxing_done
);

    localparam int MAX_DELAY_01 = (ROUND_FIRST_DELAY > ROUND_MIDDLE_DELAY) ?
                                  ROUND_FIRST_DELAY : ROUND_MIDDLE_DELAY;
    localparam int MAX_DELAY    = (MAX_DELAY_01 > ROUND_LAST_DELAY) ?
                                  MAX_DELAY_01 : ROUND_LAST_DELAY;
    localparam int NB_TIMER     = (MAX_DELAY > 1) ? $clog2(MAX_DELAY) : 1;

    // Terminal timer counts, one per kind of stage
    localparam logic [NB_TIMER-1:0] FIRST_END  = NB_TIMER'(ROUND_FIRST_DELAY - 1);
    localparam logic [NB_TIMER-1:0] MIDDLE_END = NB_TIMER'(ROUND_MIDDLE_DELAY - 1);
    localparam logic [NB_TIMER-1:0] LAST_END   = NB_TIMER'(ROUND_LAST_DELAY - 1);

    logic                     trigger;
    logic [N_ROUNDS:0]        stage_ptr;    // One-hot wavefront position, bit k is round k
    logic                     wave_active;
    logic [NB_TIMER-1:0]      timer;        // Advance cycles spent at the current stage
    logic [NB_TIMER-1:0]      timer_end;
    logic                     timer_done;
    logic                     last_step;
    logic                     load_mode;
    logic [NB_KEY_VECTOR-1:0] stored_keys;

    assign trigger     = i_trigger_loading || i_trigger_muxing;
    assign wave_active = |stage_ptr;

    always_comb
    begin
        if (stage_ptr[0])
            timer_end = FIRST_END;
        else if (stage_ptr[N_ROUNDS])
            timer_end = LAST_END;
        else
            timer_end = MIDDLE_END;
    end

    assign timer_done = wave_active && (timer == timer_end);
    assign last_step  = stage_ptr[N_ROUNDS] && timer_done;

    // Wavefront shift line, frozen while the pipeline stalls
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            stage_ptr <= '0;
        else if (i_valid)
        begin
            if (trigger)
                stage_ptr <= {{N_ROUNDS{1'b0}}, 1'b1};         // Enter at round 0
            else if (timer_done)
                stage_ptr <= {stage_ptr[N_ROUNDS-1:0], 1'b0};  // Shifts out after the last round
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            timer <= '0;
        else if (i_valid)
        begin
            if (trigger || timer_done)
                timer <= '0;
            else if (wave_active)
                timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            load_mode <= 1'b0;
        else if (i_valid && trigger)
            load_mode <= i_trigger_loading;
    end

    // Done one advance cycle after the wavefront leaves the last round
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_loading_done <= 1'b0;
            o_muxing_done  <= 1'b0;
        end
        else
        begin
            o_loading_done <= i_valid && last_step && load_mode;
            o_muxing_done  <= i_valid && last_step && !load_mode;
        end
    end

    // Copy the new round key as the wavefront passes its stage
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            stored_keys <= '0;
        else if (i_valid && load_mode)
        begin
            for (int k = 0; k <= N_ROUNDS; k++)
            begin
                if (stage_ptr[k])
                    stored_keys[k*NB_STATE +: NB_STATE] <= i_round_key_vector[k*NB_STATE +: NB_STATE];
            end
        end
    end

    // New key at the active stage, stored keys elsewhere
    always_comb
    begin
        for (int k = 0; k <= N_ROUNDS; k++)
        begin
            if (stage_ptr[k])
                o_round_key_vector[k*NB_STATE +: NB_STATE] = i_round_key_vector[k*NB_STATE +: NB_STATE];
            else
                o_round_key_vector[k*NB_STATE +: NB_STATE] = stored_keys[k*NB_STATE +: NB_STATE];
        end
    end

endmodule

`default_nettype wire

// File: rtl/key_switch_top.sv
`default_nettype none

module key_switch_top
    import aes_key_pkg::*;
#(
    parameter int ROUND_FIRST_DELAY  = 1,
    parameter int ROUND_MIDDLE_DELAY = 2,
    parameter int ROUND_LAST_DELAY   = 2
)
(
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire                      i_command_valid,
    input  wire                      i_command_load,
    input  wire [NB_STATE-1:0]       i_cipher_key,
    input  wire                      i_advance,           // Round pipeline valid
    output logic [NB_KEY_VECTOR-1:0] o_round_keys,
    output logic                     o_switch_done,
    output logic                     o_preview_done,
    output logic                     o_busy,
    output logic                     o_command_rejected
);

    logic                     expand_start;
    logic [NB_STATE-1:0]      key;             // Latched cipher key
    logic [NB_KEY_VECTOR-1:0] expanded_keys;
    logic                     expand_done;
    logic                     trigger_loading;
    logic                     trigger_muxing;

    // Decode stage
    key_command_decoder u_decoder
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_command_valid    (i_command_valid),
        .i_command_load     (i_command_load),
        .i_cipher_key       (i_cipher_key),
        .i_expand_done      (expand_done),
        .i_advance          (i_advance),
        .i_switch_done      (o_switch_done),
        .i_preview_done     (o_preview_done),
        .o_expand_start     (expand_start),
        .o_key              (key),
        .o_trigger_loading  (trigger_loading),
        .o_trigger_muxing   (trigger_muxing),
        .o_busy             (o_busy),
        .o_command_rejected (o_command_rejected)
    );

    // Execute stage
    key_expander u_expander
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_start            (expand_start),
        .i_key              (key),
        .o_round_key_vector (expanded_keys),
        .o_done             (expand_done)
    );

    // Result stage
    key_scheduler_switcher #(
        .ROUND_FIRST_DELAY  (ROUND_FIRST_DELAY),
        .ROUND_MIDDLE_DELAY (ROUND_MIDDLE_DELAY),
        .ROUND_LAST_DELAY   (ROUND_LAST_DELAY)
    ) u_switcher
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_valid            (i_advance),
        .i_trigger_loading  (trigger_loading),
        .i_trigger_muxing   (trigger_muxing),
        .i_round_key_vector (expanded_keys),
        .o_round_key_vector (o_round_keys),
        .o_loading_done     (o_switch_done),
        .o_muxing_done      (o_preview_done)
    );

endmodule

`default_nettype wire

// File: test/key_switch_chk.sv
`default_nettype none

module key_switch_chk
(
    input wire i_clock,
    input wire i_reset,
    input wire i_switch_done,
    input wire i_preview_done,
    input wire i_busy,
    input wire i_trigger_loading,
    input wire i_trigger_muxing
);
    timeunit 1ns;
    timeprecision 1ps;

    switch_done_single: assert property (@(posedge i_clock) disable iff (i_reset)
        i_switch_done |=> !i_switch_done)
        else $error("Switch done lasted more than one cycle");

    preview_done_single: assert property (@(posedge i_clock) disable iff (i_reset)
        i_preview_done |=> !i_preview_done)
        else $error("Preview done lasted more than one cycle");

    done_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_switch_done && i_preview_done))
        else $error("Switch done and preview done high together");

    // Busy ends one cycle after a done pulse
    busy_fall_after_done: assert property (@(posedge i_clock) disable iff (i_reset)
        $fell(i_busy) |-> $past(i_switch_done || i_preview_done))
        else $error("Busy fell without a done pulse");

    trigger_while_busy: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_trigger_loading || i_trigger_muxing) |-> i_busy)
        else $error("Trigger raised while not busy");

endmodule

bind key_switch_top key_switch_chk u_chk
(
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_switch_done     (o_switch_done),
    .i_preview_done    (o_preview_done),
    .i_busy            (o_busy),
    .i_trigger_loading (trigger_loading),
    .i_trigger_muxing  (trigger_muxing)
);

`default_nettype wire

// File: test/key_switch_tb.sv
`default_nettype none

module key_switch_tb
    import aes_key_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD   = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int N_COMMANDS     = 40;
    localparam int TIMEOUT_CYCLES = N_COMMANDS * 120 + RESET_CYCLES;

    logic                     clock;
    logic                     reset;
    logic                     command_valid;
    logic                     command_load;
    logic [NB_STATE-1:0]      cipher_key;
    logic                     advance;
    logic [NB_KEY_VECTOR-1:0] round_keys;
    logic                     switch_done;
    logic                     preview_done;
    logic                     busy;
    logic                     command_rejected;

    logic [31:0]              lcg_state;
    logic [NB_KEY_VECTOR-1:0] model_keys;      // Keys the switcher should hold
    logic [NB_KEY_VECTOR-1:0] target_keys;     // Expansion of the command in flight
    logic [NB_KEY_VECTOR-1:0] prev_keys;       // Output seen one cycle earlier
    logic                     in_flight;
    logic                     load_in_flight;
    logic                     expect_busy;
    logic                     expect_rejected;
    int                       prefix_count;    // New slots seen so far in a load
    int                       cycle_count;

    key_switch_top #(
        .ROUND_FIRST_DELAY  (1),
        .ROUND_MIDDLE_DELAY (2),
        .ROUND_LAST_DELAY   (2)
    ) dut
    (
        .i_clock            (clock),
        .i_reset            (reset),
        .i_command_valid    (command_valid),
        .i_command_load     (command_load),
        .i_cipher_key       (cipher_key),
        .i_advance          (advance),
        .o_round_keys       (round_keys),
        .o_switch_done      (switch_done),
        .o_preview_done     (preview_done),
        .o_busy             (busy),
        .o_command_rejected (command_rejected)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // AES-128 key schedule in FIPS-197 word order, word 0 leftmost
    function automatic logic [NB_KEY_VECTOR-1:0] expand_key(input logic [NB_STATE-1:0] key);
        logic [NB_KEY_VECTOR-1:0] keys;
        logic [NB_WORD-1:0]       w0;
        logic [NB_WORD-1:0]       w1;
        logic [NB_WORD-1:0]       w2;
        logic [NB_WORD-1:0]       w3;
        logic [NB_WORD-1:0]       temp;
        keys = '0;
        keys[NB_STATE-1:0] = key;
        {w0, w1, w2, w3} = key;
        for (int r = 1; r <= N_ROUNDS; r++)
        begin
            temp = sub_word(rot_word(w3)) ^ {rcon(NB_ROUND_INDEX'(r)), 24'h000000};
            w0 = w0 ^ temp;
            w1 = w1 ^ w0;
            w2 = w2 ^ w1;
            w3 = w3 ^ w2;
            keys[r*NB_STATE +: NB_STATE] = {w0, w1, w2, w3};
        end
        return keys;
    endfunction

    task automatic check_value(
        input string               name,
        input logic [NB_STATE-1:0] expected,
        input logic [NB_STATE-1:0] actual
    );
        if (actual !== expected)
        begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_outputs();
        logic [NB_STATE-1:0] slot;
        logic [NB_STATE-1:0] old_key;
        logic [NB_STATE-1:0] new_key;
        logic                load_active;
        logic                prefix_open;
        int                  new_count;
        int                  diff_count;
        load_active = in_flight && load_in_flight;
        prefix_open = 1'b1;
        new_count   = 0;
        diff_count  = 0;
        check_value("command rejected", NB_STATE'(expect_rejected), NB_STATE'(command_rejected));
        check_value("busy", NB_STATE'(expect_busy), NB_STATE'(busy));
        for (int k = 0; k <= N_ROUNDS; k++)
        begin
            slot    = round_keys[k*NB_STATE +: NB_STATE];
            old_key = model_keys[k*NB_STATE +: NB_STATE];
            new_key = target_keys[k*NB_STATE +: NB_STATE];
            if (!advance)   // Stalled edge freezes the output
                check_value($sformatf("stall round %0d", k), prev_keys[k*NB_STATE +: NB_STATE],
                            slot);
            if (load_active && prefix_open && slot == new_key)
                new_count++;
            else if (load_active)
            begin
                prefix_open = 1'b0;  // Beyond the wavefront only old keys
                check_value($sformatf("load round %0d", k), old_key, slot);
            end
            else if (in_flight && slot != old_key)
            begin
                diff_count++;
                check_value($sformatf("preview round %0d", k), new_key, slot);
            end
            else
                check_value($sformatf("idle round %0d", k), old_key, slot);
        end
        if (load_active)
        begin
            check_value("load prefix kept", NB_STATE'(1), NB_STATE'(new_count >= prefix_count));
            prefix_count = new_count;
        end
        check_value("preview single slot", NB_STATE'(1), NB_STATE'(diff_count <= 1));
        if (switch_done)
        begin
            check_value("switch done for a load", NB_STATE'(1), NB_STATE'(load_active));
            check_value("switch rounds updated", NB_STATE'(N_ROUNDS + 1), NB_STATE'(new_count));
            model_keys  = target_keys;
            in_flight   = 1'b0;
            expect_busy = 1'b0;
        end
        if (preview_done)
        begin
            check_value("preview done for a preview", NB_STATE'(1),
                        NB_STATE'(in_flight && !load_in_flight));
            check_value("preview rounds restored", NB_STATE'(0), NB_STATE'(diff_count));
            in_flight   = 1'b0;
            expect_busy = 1'b0;
        end
    endtask

    // Check what the last edge produced, then drive the next inputs
    task automatic drive_cycle(
        input logic                send,
        input logic                load,
        input logic [NB_STATE-1:0] key
    );
        @(negedge clock);
        check_outputs();
        prev_keys       = round_keys;
        expect_rejected = send && busy;
        if (send && !busy)
        begin
            in_flight      = 1'b1;
            load_in_flight = load;
            target_keys    = expand_key(key);
            prefix_count   = 0;
            expect_busy    = 1'b1;
        end
        command_valid = send;
        command_load  = load;
        cipher_key    = key;
        advance       = (next_random() >> 30) != 32'd0;  // High three cycles in four
    endtask

    initial
    begin
        logic [NB_KEY_VECTOR-1:0] known_keys;
        logic [NB_STATE-1:0]      key;
        logic                     load;
        logic                     rushed;
        int                       gap;
        lcg_state       = 32'd40;
        reset           = 1'b1;
        command_valid   = 1'b0;
        command_load    = 1'b0;
        cipher_key      = '0;
        advance         = 1'b0;
        model_keys      = '0;
        target_keys     = '0;
        prev_keys       = '0;
        in_flight       = 1'b0;
        load_in_flight  = 1'b0;
        expect_busy     = 1'b0;
        expect_rejected = 1'b0;
        prefix_count    = 0;

        // Known answer from the AES standard, last round key
        known_keys = expand_key(128'h2b7e151628aed2a6abf7158809cf4f3c);
        check_value("key schedule round 10", 128'hd014f9a8c9ee2589e13f0cc8b6630ca6,
                    known_keys[N_ROUNDS*NB_STATE +: NB_STATE]);

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int n = 0; n < N_COMMANDS; n++)
        begin
            gap    = next_random() >> 28;
            rushed = (next_random() >> 30) == 32'd0;  // Mostly lands while busy
            if (!rushed)
            begin
                while (busy || in_flight)
                    drive_cycle(1'b0, 1'b0, '0);
            end
            repeat (gap) drive_cycle(1'b0, 1'b0, '0);
            key  = {next_random(), next_random(), next_random(), next_random()};
            load = (next_random() >> 31) != 32'd0;
            drive_cycle(1'b1, load, key);
        end
        while (busy || in_flight)
            drive_cycle(1'b0, 1'b0, '0);
        repeat (4) drive_cycle(1'b0, 1'b0, '0);
        $display("Regression passed");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// File: all.f
rtl/aes_key_pkg.sv
rtl/key_command_decoder.sv
rtl/key_expander.sv
rtl/key_scheduler_switcher.sv
rtl/key_switch_top.sv
test/key_switch_chk.sv
test/key_switch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the key switch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module key_switch_tb -f all.f -o key_switch_sim
./obj_dir/key_switch_sim | tee sim.log
if grep -q "Regression passed" sim.log
then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
